//--- daDds.f
+incdir+rtl
+incdir+verif
rtl/ddsPkg.sv
rtl/uartReceiver.sv
rtl/freqRegFile.sv
rtl/phaseAccumulator.sv
rtl/sineOutputStage.sv
rtl/daDds.sv
verif/daDdsTb.sv

//--- runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module daDdsTb \
    -f daDds.f -o daDdsSim || { echo "build failed"; exit 1; }
./obj_dir/daDdsSim > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0

//--- verif/sineRef.svh
`ifndef SINE_REF_SVH
`define SINE_REF_SVH

// first quadrant of the sine, entry 0 at the top of the vector.
function automatic logic [7:0] sineQuarter(input int idx);
    logic [511:0] quarter;
    quarter = {
        8'h7F, 8'h82, 8'h85, 8'h88, 8'h8B, 8'h8F, 8'h92, 8'h95,
        8'h98, 8'h9B, 8'h9E, 8'hA1, 8'hA4, 8'hA7, 8'hAA, 8'hAD,
        8'hB0, 8'hB2, 8'hB5, 8'hB8, 8'hBB, 8'hBE, 8'hC0, 8'hC3,
        8'hC6, 8'hC8, 8'hCB, 8'hCD, 8'hD0, 8'hD2, 8'hD4, 8'hD7,
        8'hD9, 8'hDB, 8'hDD, 8'hDF, 8'hE1, 8'hE3, 8'hE5, 8'hE7,
        8'hE9, 8'hEA, 8'hEC, 8'hEE, 8'hEF, 8'hF0, 8'hF2, 8'hF3,
        8'hF4, 8'hF5, 8'hF7, 8'hF8, 8'hF9, 8'hF9, 8'hFA, 8'hFB,
        8'hFC, 8'hFC, 8'hFD, 8'hFD, 8'hFD, 8'hFE, 8'hFE, 8'hFE
    };
    return quarter[(63 - idx) * 8 +: 8];
endfunction

`endif

//--- verif/daDdsTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "dds_defines.svh"

module daDdsTb;

    // start bit driven at edge n, strobe at n + validLat, register at the edge after.
    localparam int validLat  = 2 + (19 * `CLKS_PER_BIT) / 2;
    localparam int idleLimit = 400;

    logic              clk;
    logic              rst;
    logic              rx;
    logic              rfData;
    logic              freqSel;
    logic [`DAC_W-1:0] dac;

    int   seed;
    int   checks;
    int   errors;
    int   timeouts;
    logic checkEn;
    logic expectMid;

    // byte on the wire, picked up by the model at the start edge.
    logic [7:0] txByte;
    logic       txStopOk;

    // reference model state.
    logic [`PHASE_W-1:0] mPhase;
    logic [`PHASE_W-1:0] mFreq0;
    logic [`PHASE_W-1:0] mFreq1;
    logic [`PHASE_W-1:0] mStep;
    logic [7:0]          mLow;
    logic                mExpectHigh;
    logic [`DAC_W-1:0]   mDac;
    logic                mBusy;
    logic                mPrevRx;
    logic [7:0]          mByte;
    logic                mStopOk;
    int                  mCycle;
    int                  mDeliverAt;

    `include "sineRef.svh"

    daDds UUT (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .rfData  (rfData),
        .freqSel (freqSel),
        .dac     (dac)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // quadrant folding as a table lookup, plus OOK blanking.
    function automatic logic [`DAC_W-1:0] expectedDac(input logic [`PHASE_W-1:0] ph,
            input logic [`PHASE_W-1:0] f1, input logic rf);
        int p;
        int idx;
        int entry;
        if (f1 == '0 && !rf) return `DAC_W'(`DAC_MID);
        p = int'(ph) >> (`PHASE_W - 8);
        if (p < 64 || (p >= 128 && p < 192)) begin
            idx = p % 64;
        end else begin
            idx = 63 - p % 64;
        end
        entry = int'(sineQuarter(idx));
        if (p >= 128) entry = 255 - entry;
        return `DAC_W'(entry);
    endfunction

    task automatic checkValue(input string name, input logic [`DAC_W-1:0] got,
            input logic [`DAC_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // cycle model. reads inputs as they stood before the edge.
    always @(posedge clk) begin
        if (rst) begin
            mPhase      = '0;
            mFreq0      = '0;
            mFreq1      = '0;
            mLow        = '0;
            mExpectHigh = 1'b0;
            mDac        = `DAC_W'(`DAC_MID);
            mBusy       = 1'b0;
            mPrevRx     = rx;
            mCycle      = 0;
        end else begin
            mCycle++;
            mDac   = expectedDac(mPhase, mFreq1, rfData);
            mStep  = rfData ? mFreq1 : mFreq0;
            mPhase = mPhase + mStep;
            if (mBusy && mCycle == mDeliverAt) begin
                mBusy = 1'b0;
                if (mStopOk) begin
                    if (mExpectHigh) begin
                        if (freqSel) begin
                            mFreq1 = {mByte, mLow};
                        end else begin
                            mFreq0 = {mByte, mLow};
                        end
                    end else begin
                        mLow = mByte;
                    end
                    mExpectHigh = !mExpectHigh;
                end
            end
            // start bit seen one edge after it was driven.
            if (!mBusy && mPrevRx && !rx) begin
                mBusy      = 1'b1;
                mDeliverAt = mCycle + validLat;
                mByte      = txByte;
                mStopOk    = txStopOk;
            end
            mPrevRx = rx;
        end
    end

    always @(negedge clk) begin
        if (checkEn) checkValue("dac", dac, mDac);
        if (expectMid) checkValue("dac", dac, `DAC_W'(`DAC_MID));
    end

    task automatic sendByte(input logic [7:0] data, input logic stopOk);
        @(posedge clk);
        txByte   = data;
        txStopOk = stopOk;
        rx <= 1'b0;
        repeat (`CLKS_PER_BIT) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            rx <= data[i]; // lsb first.
            repeat (`CLKS_PER_BIT) @(posedge clk);
        end
        rx <= stopOk;
        repeat (`CLKS_PER_BIT) @(posedge clk);
        rx <= 1'b1;
    endtask

    task automatic waitModelIdle(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (mBusy && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (mBusy) begin
            timeouts++;
            $display("timeout: frequency word never landed after %0d cycles", limit);
        end
    endtask

    task automatic writeWord(input logic [`PHASE_W-1:0] word, input logic sel);
        @(posedge clk);
        freqSel <= sel;
        sendByte(word[7:0], 1'b1);
        repeat (2) @(posedge clk);
        sendByte(word[15:8], 1'b1);
        waitModelIdle(idleLimit);
    endtask

    task automatic toggleRf(input int segments);
        int hold;
        for (int s = 0; s < segments; s++) begin
            @(posedge clk);
            rfData <= ~rfData;
            hold = 1 + int'($unsigned($random(seed)) % 8);
            repeat (hold - 1) @(posedge clk);
        end
    endtask

    initial begin : stimulus
        logic [`PHASE_W-1:0] word;
        logic [7:0]          junk;
        seed      = 32'h29d2_769f;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        checkEn   = 1'b0;
        expectMid = 1'b0;
        txByte    = '0;
        txStopOk  = 1'b1;
        rst       = 1'b1;
        rx        = 1'b1;
        rfData    = 1'b0;
        freqSel   = 1'b0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        checkEn = 1'b1;

        // both registers zero, so the carrier is keyed off.
        expectMid = 1'b1;
        repeat (20) @(posedge clk);
        expectMid = 1'b0;

        word = `PHASE_W'($random(seed));
        writeWord(word, 1'b0);
        @(posedge clk);
        rfData <= 1'b1; // freq1 still zero, phase holds.
        repeat (50) @(posedge clk);
        rfData <= 1'b0;

        word = `PHASE_W'($random(seed));
        if (word == '0) word = 16'h0001;
        writeWord(word, 1'b1);
        @(posedge clk);
        rfData <= 1'b1;
        repeat (200) @(posedge clk);

        toggleRf(80);

        // framing error first, then a clean pair with rfData moving.
        junk = 8'($random(seed));
        sendByte(junk, 1'b0);
        repeat (3) @(posedge clk);
        word = `PHASE_W'($random(seed));
        fork
            writeWord(word, 1'b0);
            toggleRf(40);
        join
        toggleRf(30);

        // back to OOK.
        writeWord('0, 1'b1);
        toggleRf(80);
        repeat (10) @(posedge clk);

        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/daDds.sv
`timescale 1ns/10ps
`default_nettype none

`include "dds_defines.svh"

module daDds (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         rx,
    input  wire logic         rfData,
    input  wire logic         freqSel,
    output logic [`DAC_W-1:0] dac
);
    import ddsPkg::*;

    rxByte_t             rxByte;
    tuning_t             tuning;
    logic [`PHASE_W-1:0] phase;

    uartReceiver uart (
        .clk    (clk),
        .rst    (rst),
        .rx     (rx),
        .rxByte (rxByte)
    );

    freqRegFile regs (
        .clk     (clk),
        .rst     (rst),
        .rxByte  (rxByte),
        .freqSel (freqSel),
        .tuning  (tuning)
    );

    phaseAccumulator accum (
        .clk    (clk),
        .rst    (rst),
        .rfData (rfData),
        .tuning (tuning),
        .phase  (phase)
    );

    sineOutputStage outStage (
        .phase  (phase),
        .clk    (clk),
        .rst    (rst),
        .tuning (tuning),
        .rfData (rfData),
        .dac    (dac)
    );

endmodule

`default_nettype wire

//--- rtl/sineOutputStage.sv
`timescale 1ns/10ps
`default_nettype none

`include "dds_defines.svh"

module sineOutputStage (
    input  wire logic [`PHASE_W-1:0] phase,
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire ddsPkg::tuning_t     tuning,
    input  wire logic                rfData,
    output logic [`DAC_W-1:0]        dac
);

    // first quadrant of the sine in offset binary.
    localparam logic [`DAC_W-1:0] quarterTable [64] = '{
        8'h7F, 8'h82, 8'h85, 8'h88, 8'h8B, 8'h8F, 8'h92, 8'h95,
        8'h98, 8'h9B, 8'h9E, 8'hA1, 8'hA4, 8'hA7, 8'hAA, 8'hAD,
        8'hB0, 8'hB2, 8'hB5, 8'hB8, 8'hBB, 8'hBE, 8'hC0, 8'hC3,
        8'hC6, 8'hC8, 8'hCB, 8'hCD, 8'hD0, 8'hD2, 8'hD4, 8'hD7,
        8'hD9, 8'hDB, 8'hDD, 8'hDF, 8'hE1, 8'hE3, 8'hE5, 8'hE7,
        8'hE9, 8'hEA, 8'hEC, 8'hEE, 8'hEF, 8'hF0, 8'hF2, 8'hF3,
        8'hF4, 8'hF5, 8'hF7, 8'hF8, 8'hF9, 8'hF9, 8'hFA, 8'hFB,
        8'hFC, 8'hFC, 8'hFD, 8'hFD, 8'hFD, 8'hFE, 8'hFE, 8'hFE
    };

    localparam logic [`DAC_W-1:0] midScale = `DAC_W'(`DAC_MID);

    logic [7:0]        phaseTop;
    logic [5:0]        tableIdx;
    logic [`DAC_W-1:0] entry;
    logic [`DAC_W-1:0] sample;
    logic [`DAC_W-1:0] nextDac;
    logic              ookOff;

    assign phaseTop = phase[`PHASE_W-1 -: 8];

    // quadrants 1 and 3 walk the table backwards.
    assign tableIdx = phaseTop[6] ? 6'd63 - phaseTop[5:0] : phaseTop[5:0];
    assign entry    = quarterTable[tableIdx];

    // lower half of the cycle mirrors about mid-scale.
    assign sample = phaseTop[7] ? ~entry : entry; // same as 255 - entry.

    // freq1 never programmed means the carrier is keyed by rfData.
    assign ookOff  = (tuning.freq1 == '0) && !rfData;
    assign nextDac = ookOff ? midScale : sample;

    always_ff @(posedge clk) begin
        if (rst) begin
            dac <= midScale;
        end else begin
            dac <= nextDac;
        end
    end

    ookBlank: assert property (@(posedge clk) disable iff (rst)
        (tuning.freq1 == '0 && !rfData) |=> (dac == `DAC_W'(`DAC_MID)));

endmodule

`default_nettype wire

//--- rtl/phaseAccumulator.sv
`timescale 1ns/10ps
`default_nettype none

`include "dds_defines.svh"

module phaseAccumulator (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            rfData,
    input  wire ddsPkg::tuning_t tuning,
    output logic [`PHASE_W-1:0]  phase
);

    logic [`PHASE_W-1:0] step;

    // fsk. rfData picks the tuning word.
    assign step = rfData ? tuning.freq1 : tuning.freq0;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else begin
            phase <= phase + step; // wraps mod 2^PHASE_W.
        end
    end

endmodule

`default_nettype wire

//--- rtl/freqRegFile.sv
`timescale 1ns/10ps
`default_nettype none

`include "dds_defines.svh"

module freqRegFile (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire ddsPkg::rxByte_t rxByte,
    input  wire logic            freqSel,
    output ddsPkg::tuning_t      tuning
);

    logic [7:0]          lowByte;
    logic                expectHigh; // pair pointer.
    logic [`PHASE_W-1:0] freq0Q;
    logic [`PHASE_W-1:0] freq1Q;
    logic [`PHASE_W-1:0] fullWord;

    assign fullWord = {rxByte.data, lowByte};

    always_ff @(posedge clk) begin
        if (rst) begin
            expectHigh <= 1'b0;
            freq0Q     <= '0;
            freq1Q     <= '0;
        end else if (rxByte.valid) begin
            expectHigh <= !expectHigh;
            // freqSel only matters on the closing byte.
            if (expectHigh) begin
                if (freqSel) begin
                    freq1Q <= fullWord;
                end else begin
                    freq0Q <= fullWord;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rxByte.valid && !expectHigh) lowByte <= rxByte.data;
    end

    assign tuning = '{freq1: freq1Q, freq0: freq0Q};

    // writes land one cycle after the high byte strobe, never otherwise.
    writeOnPair: assert property (@(posedge clk) disable iff (rst)
        $changed(tuning) |-> $past(rxByte.valid && expectHigh));

endmodule

`default_nettype wire

//--- rtl/uartReceiver.sv
`timescale 1ns/10ps
`default_nettype none

`include "dds_defines.svh"

module uartReceiver (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     rx,
    output ddsPkg::rxByte_t rxByte
);
    import ddsPkg::*;

    localparam int baudW = $clog2(`CLKS_PER_BIT);
    localparam logic [baudW-1:0] bitEnd = baudW'(`CLKS_PER_BIT - 1);
    localparam logic [baudW-1:0] midBit = baudW'(`CLKS_PER_BIT / 2 - 1);

    uartState_t       state;
    logic [1:0]       rxSync;
    logic             rxPrev;
    logic [baudW-1:0] baudCnt;
    logic [2:0]       bitCnt;
    logic [7:0]       shiftReg;
    logic             validQ;
    logic             startEdge;

    always_ff @(posedge clk) begin
        if (rst) begin
            rxSync <= 2'b11; // line idles high.
            rxPrev <= 1'b1;
        end else begin
            rxSync <= {rxSync[0], rx};
            rxPrev <= rxSync[1];
        end
    end

    // arm only on a falling edge, so a low line after a bad stop is ignored.
    assign startEdge = !rxSync[1] && rxPrev;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idleSt;
            baudCnt <= '0;
            bitCnt  <= '0;
            validQ  <= 1'b0;
        end else begin
            validQ <= 1'b0;
            case (state)
                idleSt: begin
                    baudCnt <= baudW'(1); // edge cycle counts as first tick.
                    if (startEdge) state <= startSt;
                end
                startSt: begin
                    if (baudCnt == midBit) begin
                        baudCnt <= '0;
                        bitCnt  <= '0;
                        state   <= rxSync[1] ? idleSt : dataSt; // glitch check.
                    end else begin
                        baudCnt <= baudCnt + 1'b1;
                    end
                end
                dataSt: begin
                    if (baudCnt == bitEnd) begin
                        baudCnt <= '0;
                        bitCnt  <= bitCnt + 1'b1;
                        if (bitCnt == 3'd7) state <= stopSt;
                    end else begin
                        baudCnt <= baudCnt + 1'b1;
                    end
                end
                stopSt: begin
                    if (baudCnt == bitEnd) begin
                        validQ <= rxSync[1]; // bad stop drops the byte.
                        state  <= idleSt;
                    end else begin
                        baudCnt <= baudCnt + 1'b1;
                    end
                end
                default: state <= idleSt;
            endcase
        end
    end

    // lsb first.
    always_ff @(posedge clk) begin
        if (state == dataSt && baudCnt == bitEnd) shiftReg <= {rxSync[1], shiftReg[7:1]};
    end

    assign rxByte = '{valid: validQ, data: shiftReg};

    validSingle: assert property (@(posedge clk) disable iff (rst)
        rxByte.valid |=> !rxByte.valid);

    stateKnown: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state));

endmodule

`default_nettype wire

//--- rtl/ddsPkg.sv
`default_nettype none

`include "dds_defines.svh"

package ddsPkg;

    typedef enum logic [1:0] {
        idleSt,
        startSt,
        dataSt,
        stopSt
    } uartState_t;

    // one received byte with its strobe.
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rxByte_t;

    typedef struct packed {
        logic [`PHASE_W-1:0] freq1;
        logic [`PHASE_W-1:0] freq0;
    } tuning_t;

endpackage

`default_nettype wire

//--- rtl/dds_defines.svh
`ifndef DDS_DEFINES_SVH
`define DDS_DEFINES_SVH

// serial line timing.
`define CLKS_PER_BIT 16 // keep even for a clean mid-bit sample.

// datapath widths.
`define PHASE_W 16
`define DAC_W 8

// mid-scale code, both the OOK off level and the reset level.
`define DAC_MID 128

`endif
